// File: dcache_stimulus.txt
// columns: op address size(0 byte, 1 half, 2 word, 3 double) store_data expected_word
// ops: rm read miss, rh read hit, wr store, sn snoop invalidate, wb write-back line base and beat 0
rm 00001090 3 0 A5A5A5A5A5A5B535
rh 000010B8 3 0 A5A5A5A5A5A5B51D
wr 00001083 0 5A 0
wr 0000108A 1 1234 0
wr 00001094 2 DEADBEEF 0
wr 000010A0 3 0123456789ABCDEF 0
rh 00001080 3 0 A5A5A5A55AA5B525
rh 00001088 3 0 A5A5A5A51234B52D
rh 00001090 3 0 DEADBEEFA5A5B535
rh 000010A0 3 0 0123456789ABCDEF
rm 00001480 3 0 A5A5A5A5A5A5B125
rm 00001888 3 0 A5A5A5A5A5A5BD2D
rm 00001CB0 3 0 A5A5A5A5A5A5B915
rm 00002080 3 0 A5A5A5A5A5A58525
wb 00001080 3 0 A5A5A5A55AA5B525
rm 000010A0 3 0 0123456789ABCDEF
wr 00001480 3 FFFF0000FFFF0000 0
rh 00001480 3 0 FFFF0000FFFF0000
sn 00001480 3 0 0
rm 00001480 3 0 A5A5A5A5A5A5B125

// File: dcache_top.f
cache_geom_pkg.sv
mem_bus_pkg.sv
lru_if.sv
dcache_lru.sv
dcache_ctrl.sv
dcache_top.sv
axi_mem_model.sv
dcache_tb.sv

// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --timescale 1ns/10ps \
    -f dcache_top.f --top-module dcache_tb -o dcache_sim
output=$(./obj_dir/dcache_sim || true)
echo "$output"
echo "$output" | grep -q "^Simulation passed$"

// File: dcache_tb.sv
`timescale 1ns/10ps

module dcache_tb import cache_geom_pkg::*, mem_bus_pkg::*; ();

    logic         clk = 1'b0;
    logic         reset;
    addr_t        addr;
    data_t        wdata;
    access_size_e wlen;
    logic         enable, wrn;
    data_t        rdata;
    logic         valid, write_done;
    addr_t        awaddr;
    logic         awvalid, awready;
    data_t        wdata_out;
    logic         wlast, wvalid, wready, bvalid, bready;
    addr_t        araddr;
    logic         arvalid, arready;
    data_t        rdata_in;
    logic         rlast, rvalid, rready;
    logic         acvalid, acready;
    addr_t        acaddr;
    snoop_e       acsnoop;
    logic         snoop_req;
    addr_t        snoop_addr, last_araddr, wb_addr;
    int           ar_count, wb_count;
    data_t        wb_beat0;

    logic [15:0]  op_q [$];  // two-letter operation codes
    addr_t        addr_q [$];
    logic [1:0]   size_q [$];
    data_t        data_q [$];
    data_t        exp_q [$];
    logic         loaded = 1'b0;
    int           errors = 0;
    int           checks = 0;
    int           wb_expected = 0;

    dcache_top #(.SETS(16)) dut0 (.*);

    axi_mem_model mem0 (.*);

    always #50 clk = ~clk;

    task automatic check_data(input string name, input data_t got, input data_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_addr(input string name, input addr_t got, input addr_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic load_stimulus();
        int                fd;
        int                n;
        logic              done;
        logic [15:0]       op;
        logic [8*128-1:0]  skip;
        addr_t             a;
        logic [1:0]        sz;
        data_t             d, e;
        done = 1'b0;
        fd = $fopen("dcache_stimulus.txt", "r");
        if (fd == 0) begin
            $display("ERROR: the stimulus file dcache_stimulus.txt could not be opened");
            errors++;
            return;
        end
        while (!done) begin
            n = $fscanf(fd, "%s", op);
            if (n != 1) begin
                done = 1'b1;
            end else if (op == "//") begin
                n = $fgets(skip, fd);  // rest of a comment line
            end else begin
                n = $fscanf(fd, "%h %h %h %h", a, sz, d, e);
                if (n != 4) begin
                    $display("ERROR: a stimulus line has missing columns");
                    errors++;
                end
                op_q.push_back(op);
                addr_q.push_back(a);
                size_q.push_back(sz);
                data_q.push_back(d);
                exp_q.push_back(e);
            end
        end
        $fclose(fd);
    endtask

    // hold the request until the cache answers
    task automatic do_access(input addr_t a, input logic [1:0] sz, input data_t d,
                             input logic w, output data_t got);
        addr   = a;
        wdata  = d;
        wlen   = access_size_e'(sz);
        wrn    = w;
        enable = 1'b1;
        @(negedge clk);
        while (!(valid || write_done))
            @(negedge clk);
        check_flag("valid", valid, !w);
        check_flag("write_done", write_done, w);
        got = rdata;
        @(posedge clk);
        #1 enable = 1'b0;
    endtask

    task automatic run_op(input int i);
        int    ar_before;
        data_t got;
        ar_before = ar_count;
        @(posedge clk);
        #1;
        case (op_q[i])
            "rm", "rh": begin
                do_access(addr_q[i], size_q[i], 64'h0, 1'b0, got);
                check_data("rdata", got, exp_q[i]);
            end
            "wr": do_access(addr_q[i], size_q[i], data_q[i], 1'b1, got);
            "sn": begin
                snoop_req  = 1'b1;
                snoop_addr = addr_q[i];
                @(negedge clk);
                while (!(acvalid && acready))
                    @(negedge clk);
                @(posedge clk);
                #1 snoop_req = 1'b0;
            end
            "wb": begin
                wb_expected++;
                check_flag("write-back burst seen", wb_count == wb_expected, 1'b1);
                check_addr("awaddr", wb_addr, addr_q[i]);
                check_data("wdata_out beat 0", wb_beat0, exp_q[i]);
            end
            default: begin
                $display("ERROR: unknown operation at stimulus entry %0d", i);
                errors++;
            end
        endcase
        if (op_q[i] == "rm") begin
            check_flag("arvalid burst issued", ar_count == ar_before + 1, 1'b1);
            check_addr("araddr", last_araddr, addr_q[i] & ~addr_t'(WORD_BYTES - 1));
        end else if (op_q[i] == "rh" || op_q[i] == "wr") begin
            check_flag("arvalid burst issued", ar_count != ar_before, 1'b0);
        end
    endtask

    initial begin
        reset      = 1'b1;
        addr       = '0;
        wdata      = '0;
        wlen       = SIZE_D;
        enable     = 1'b0;
        wrn        = 1'b0;
        snoop_req  = 1'b0;
        snoop_addr = '0;
        load_stimulus();
        loaded = 1'b1;
        repeat (10) @(posedge clk);
        #1 reset = 1'b0;
        @(negedge clk);
        check_flag("valid", valid, 1'b0);
        check_flag("write_done", write_done, 1'b0);
        check_flag("awvalid", awvalid, 1'b0);
        check_flag("wvalid", wvalid, 1'b0);
        check_flag("arvalid", arvalid, 1'b0);
        check_flag("rready", rready, 1'b0);
        check_flag("acready", acready, 1'b1);
        check_flag("bready", bready, 1'b1);
        for (int i = 0; i < op_q.size(); i++)
            run_op(i);
        check_flag("write-back count", wb_count == wb_expected, 1'b1);
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0)
            $display("Simulation passed");
        else
            $display("Simulation failed");
        $finish;
    end

    // 2000 cycles per stimulus entry plus one share for reset
    initial begin
        wait (loaded == 1'b1);
        #((op_q.size() + 1) * 2000 * 100);
        $display("ERROR: watchdog timeout, the stimulus did not complete in time");
        $display("checks %0d, errors %0d", checks, errors + 1);
        $display("Simulation failed");
        $finish;
    end

endmodule

// File: axi_mem_model.sv
`timescale 1ns/10ps

module axi_mem_model import cache_geom_pkg::*, mem_bus_pkg::*; (
    input  logic   clk,
    input  addr_t  awaddr,
    input  logic   awvalid,
    output logic   awready,
    input  data_t  wdata_out,
    input  logic   wlast,
    input  logic   wvalid,
    output logic   wready,
    output logic   bvalid,
    input  addr_t  araddr,
    input  logic   arvalid,
    output logic   arready,
    output data_t  rdata_in,
    output logic   rlast,
    output logic   rvalid,
    input  logic   rready,
    output logic   acvalid,
    input  logic   acready,
    output addr_t  acaddr,
    output snoop_e acsnoop,
    input  logic   snoop_req,    // level that raises one snoop
    input  addr_t  snoop_addr,
    output int     ar_count,     // refill bursts accepted
    output addr_t  last_araddr,
    output int     wb_count,     // write-back bursts completed
    output addr_t  wb_addr,
    output data_t  wb_beat0
);

    localparam data_t FILL_PATTERN = 64'hA5A5_A5A5_A5A5_A5A5;

    data_t       mem [addr_t];  // only written words are stored
    int          seed = 89214;
    logic [31:0] rnd;
    addr_t       w_base, r_line;
    offset_t     w_beat, r_word;
    int          r_left;        // refill beats still to send
    logic        aw_hs, w_hs, ar_hs, r_hs, ac_hs, snoop_seen, last_w;

    function automatic data_t read_word(addr_t a);
        addr_t wa;
        wa = {a[ADDR_BITS-1:BYTE_BITS], 3'b000};
        if (mem.exists(wa))
            return mem[wa];
        return {32'h0, wa} ^ FILL_PATTERN;  // untouched memory
    endfunction

    initial begin
        awready     = 1'b0;
        wready      = 1'b0;
        bvalid      = 1'b0;
        arready     = 1'b0;
        rdata_in    = '0;
        rlast       = 1'b0;
        rvalid      = 1'b0;
        acvalid     = 1'b0;
        acaddr      = '0;
        acsnoop     = SNOOP_NONE;
        ar_count    = 0;
        wb_count    = 0;
        last_araddr = '0;
        wb_addr     = '0;
        wb_beat0    = '0;
        w_base      = '0;
        r_line      = '0;
        w_beat      = '0;
        r_word      = '0;
        r_left      = 0;
        forever begin
            @(negedge clk);  // handshakes are decided on stable levels
            aw_hs      = awvalid && awready;
            w_hs       = wvalid && wready;
            ar_hs      = arvalid && arready;
            r_hs       = rvalid && rready;
            ac_hs      = acvalid && acready;
            snoop_seen = snoop_req;
            last_w     = w_hs && wlast;
            if (aw_hs) begin
                w_base = awaddr;
                w_beat = '0;
            end
            if (w_hs) begin
                mem[{w_base[ADDR_BITS-1:LINE_BITS], w_beat, 3'b000}] = wdata_out;
                if (w_beat == '0)
                    wb_beat0 = wdata_out;
                w_beat = w_beat + 1'b1;
                if (wlast) begin
                    wb_count++;
                    wb_addr = w_base;
                end
            end
            if (ar_hs) begin
                ar_count++;
                last_araddr = araddr;
                r_line      = {araddr[ADDR_BITS-1:LINE_BITS], {LINE_BITS{1'b0}}};
                r_word      = araddr[LINE_BITS-1:BYTE_BITS];  // critical word first
                r_left      = AXI_BURST_BEATS;
            end
            if (r_hs) begin
                r_word = r_word + 1'b1;  // wraps inside the line
                r_left--;
            end

            @(posedge clk);
            #1;
            rnd      = $random(seed);
            awready  = rnd[0];
            wready   = rnd[1] | rnd[4];
            arready  = rnd[2];
            rvalid   = r_left > 0 && (rnd[3] | rnd[5]);
            rlast    = r_left == 1;
            rdata_in = read_word({r_line[ADDR_BITS-1:LINE_BITS], r_word, 3'b000});
            bvalid   = last_w;  // one response per burst
            if (ac_hs) begin
                acvalid = 1'b0;
                acsnoop = SNOOP_NONE;
            end else if (snoop_seen && !acvalid) begin
                acvalid = 1'b1;
                acaddr  = snoop_addr;
                acsnoop = SNOOP_INVALIDATE;
            end
        end
    end

endmodule

// File: dcache_top.sv
`timescale 1ns/10ps

module dcache_top import cache_geom_pkg::*, mem_bus_pkg::*; #(
    parameter int SETS = 16
) (
    input  logic          clk,
    input  logic          reset,
    input  addr_t         addr,
    input  data_t         wdata,
    input  access_size_e  wlen,
    input  logic          enable,
    input  logic          wrn,
    output data_t         rdata,
    output logic          valid,
    output logic          write_done,
    output addr_t         awaddr,
    output logic          awvalid,
    input  logic          awready,
    output data_t         wdata_out,
    output logic          wlast,
    output logic          wvalid,
    input  logic          wready,
    input  logic          bvalid,
    output logic          bready,
    output addr_t         araddr,
    output logic          arvalid,
    input  logic          arready,
    input  data_t         rdata_in,
    input  logic          rlast,
    input  logic          rvalid,
    output logic          rready,
    input  logic          acvalid,
    output logic          acready,
    input  addr_t         acaddr,
    input  snoop_e        acsnoop
);

    lru_if #(.SETS(SETS)) lru_bus ();  // victim lookup and hit updates

    dcache_ctrl #(.SETS(SETS)) ctrl0 (
        .*,
        .lru (lru_bus.ctrl_mp)
    );

    dcache_lru #(.SETS(SETS)) lru0 (
        .clk   (clk),
        .reset (reset),
        .lru   (lru_bus.lru_mp)
    );

endmodule

// File: dcache_ctrl.sv
`timescale 1ns/10ps

module dcache_ctrl import cache_geom_pkg::*, mem_bus_pkg::*; #(
    parameter int SETS = 16
) (
    input  logic          clk,
    input  logic          reset,
    input  addr_t         addr,
    input  data_t         wdata,
    input  access_size_e  wlen,
    input  logic          enable,
    input  logic          wrn,         // 1 store, 0 load
    output data_t         rdata,
    output logic          valid,
    output logic          write_done,
    output addr_t         awaddr,
    output logic          awvalid,
    input  logic          awready,
    output data_t         wdata_out,
    output logic          wlast,
    output logic          wvalid,
    input  logic          wready,
    input  logic          bvalid,
    output logic          bready,
    output addr_t         araddr,
    output logic          arvalid,
    input  logic          arready,
    input  data_t         rdata_in,
    input  logic          rlast,
    input  logic          rvalid,
    output logic          rready,
    input  logic          acvalid,
    output logic          acready,
    input  addr_t         acaddr,
    input  snoop_e        acsnoop,
    lru_if.ctrl_mp        lru
);

    localparam int INDEX_BITS = $clog2(SETS);
    localparam int TAG_BITS   = ADDR_BITS - INDEX_BITS - LINE_BITS;

    typedef logic [INDEX_BITS-1:0] index_t;
    typedef logic [TAG_BITS-1:0]   tag_t;

    data_t                    data_mem [SETS][WAYS][LINE_WORDS];
    tag_t                     tag_mem  [SETS][WAYS];
    logic [SETS-1:0][WAYS-1:0] valid_q;
    logic [SETS-1:0][WAYS-1:0] dirty_q;

    cache_state_e state;
    addr_t        miss_addr;   // request that missed
    way_t         miss_way;    // line being replaced
    offset_t      beat;        // word of the current burst beat
    logic [3:0]   b_count;     // write responses still owed

    tag_t    req_tag, miss_tag, snoop_tag;
    index_t  req_idx, miss_idx, snoop_idx;
    offset_t req_word, miss_word;
    byte_off_t req_byte;

    logic            hit;
    way_t            hit_way;
    logic            access;
    logic            snoop_take;
    logic            victim_dirty;
    logic            last_w_beat;
    byte_off_t       aligned;
    logic [WORD_BYTES-1:0] base_mask, byte_mask;
    data_t           shifted, merged;

    assign req_tag   = addr[ADDR_BITS-1 -: TAG_BITS];
    assign req_idx   = addr[LINE_BITS +: INDEX_BITS];
    assign req_word  = addr[BYTE_BITS +: OFFSET_BITS];
    assign req_byte  = addr[BYTE_BITS-1:0];
    assign miss_tag  = miss_addr[ADDR_BITS-1 -: TAG_BITS];
    assign miss_idx  = miss_addr[LINE_BITS +: INDEX_BITS];
    assign miss_word = miss_addr[BYTE_BITS +: OFFSET_BITS];
    assign snoop_tag = acaddr[ADDR_BITS-1 -: TAG_BITS];
    assign snoop_idx = acaddr[LINE_BITS +: INDEX_BITS];

    always_comb begin
        hit     = 1'b0;
        hit_way = '0;
        for (int w = 0; w < WAYS; w++) begin
            if (valid_q[req_idx][w] && tag_mem[req_idx][w] == req_tag) begin
                hit     = 1'b1;
                hit_way = way_t'(w);
            end
        end
    end

    assign access     = enable && state == ST_IDLE && !acvalid;  // snoop has priority
    assign snoop_take = acvalid && acready;
    assign rdata      = data_mem[req_idx][hit_way][req_word];
    assign valid      = access && hit && !wrn;
    assign write_done = access && hit && wrn;

    // store data sits in the low bytes of wdata and moves to its lane
    always_comb begin
        case (wlen)
            SIZE_B: begin
                base_mask = 8'h01;
                aligned   = req_byte;
            end
            SIZE_H: begin
                base_mask = 8'h03;
                aligned   = {req_byte[2:1], 1'b0};
            end
            SIZE_W: begin
                base_mask = 8'h0f;
                aligned   = {req_byte[2], 2'b00};
            end
            default: begin
                base_mask = 8'hff;
                aligned   = '0;
            end
        endcase
        byte_mask = base_mask << aligned;
        shifted   = wdata << {aligned, 3'b000};
        for (int b = 0; b < WORD_BYTES; b++)
            merged[8*b +: 8] = byte_mask[b] ? shifted[8*b +: 8] : rdata[8*b +: 8];
    end

    assign lru.index           = req_idx;
    assign lru.touch           = valid || write_done;
    assign lru.touch_way       = hit_way;
    assign lru.fill_valid_mask = valid_q[req_idx];

    assign victim_dirty = valid_q[req_idx][lru.victim] && dirty_q[req_idx][lru.victim];

    assign awaddr    = {tag_mem[miss_idx][miss_way], miss_idx, {LINE_BITS{1'b0}}};
    assign araddr    = {miss_addr[ADDR_BITS-1:BYTE_BITS], {BYTE_BITS{1'b0}}};
    assign wdata_out = data_mem[miss_idx][miss_way][beat];
    assign wlast     = beat == offset_t'(LINE_WORDS - 1);
    assign awvalid   = state == ST_WB_ADDR;
    assign wvalid    = state == ST_WB_DATA;
    assign arvalid   = state == ST_FILL_ADDR;
    assign rready    = state == ST_FILL_DATA;
    assign acready   = state == ST_IDLE;
    assign bready    = 1'b1;

    assign last_w_beat = wvalid && wready && wlast;

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= ST_IDLE;
            valid_q <= '0;
            dirty_q <= '0;
            beat    <= '0;
            b_count <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (snoop_take && acsnoop == SNOOP_INVALIDATE) begin
                        for (int w = 0; w < WAYS; w++) begin
                            if (valid_q[snoop_idx][w] && tag_mem[snoop_idx][w] == snoop_tag) begin
                                valid_q[snoop_idx][w] <= 1'b0;
                                dirty_q[snoop_idx][w] <= 1'b0;
                            end
                        end
                    end else if (write_done) begin
                        dirty_q[req_idx][hit_way] <= 1'b1;
                    end else if (access && !hit) begin
                        beat  <= '0;
                        state <= victim_dirty ? ST_WB_ADDR : ST_FILL_ADDR;
                    end
                end
                ST_WB_ADDR: begin
                    if (awready)
                        state <= ST_WB_DATA;
                end
                ST_WB_DATA: begin
                    if (wready) begin
                        beat <= beat + 1'b1;
                        if (wlast) begin
                            dirty_q[miss_idx][miss_way] <= 1'b0;
                            state <= ST_FILL_ADDR;
                        end
                    end
                end
                ST_FILL_ADDR: begin
                    valid_q[miss_idx][miss_way] <= 1'b0;  // tag changes this cycle
                    beat <= miss_word;                    // wrap starts at the critical word
                    if (arready)
                        state <= ST_FILL_DATA;
                end
                ST_FILL_DATA: begin
                    if (rvalid) begin
                        beat <= beat + 1'b1;
                        if (rlast) begin
                            valid_q[miss_idx][miss_way] <= 1'b1;
                            dirty_q[miss_idx][miss_way] <= 1'b0;
                            state <= ST_IDLE;
                        end
                    end
                end
                default: state <= ST_IDLE;
            endcase

            if (last_w_beat && !bvalid)
                b_count <= b_count + 1'b1;
            else if (bvalid && !last_w_beat)
                b_count <= b_count - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (access && !hit) begin
            miss_addr <= addr;
            miss_way  <= lru.victim;
        end
        if (write_done)
            data_mem[req_idx][hit_way][req_word] <= merged;
        if (state == ST_FILL_ADDR)
            tag_mem[miss_idx][miss_way] <= miss_tag;
        if (rready && rvalid)
            data_mem[miss_idx][miss_way][beat] <= rdata_in;
    end

    // memory ends the refill after one full wrap of the line
    a_fill_wraps: assert property (@(posedge clk) disable iff (reset)
        rready && rvalid && rlast |-> beat == offset_t'(miss_word - 1'b1));

    // the held request hits right after its refill
    a_refill_hits: assert property (@(posedge clk) disable iff (reset)
        rready && rvalid && rlast |=> hit || !enable);

    // a write-back never carries the line that missed
    a_wb_other_line: assert property (@(posedge clk) disable iff (reset)
        awvalid |-> awaddr[ADDR_BITS-1:LINE_BITS] != miss_addr[ADDR_BITS-1:LINE_BITS]);

    // a write response only follows a completed write-back burst
    a_b_expected: assert property (@(posedge clk) disable iff (reset)
        bvalid |-> b_count != 4'd0);

endmodule

// File: dcache_lru.sv
`timescale 1ns/10ps

module dcache_lru import cache_geom_pkg::*; #(
    parameter int SETS = 16
) (
    input logic    clk,
    input logic    reset,
    lru_if.lru_mp  lru
);

    lru_t [SETS-1:0] tree_q;
    lru_t            cur_tree;
    way_t            tree_way;

    // point every node on the path away from the way just used
    function automatic lru_t point_away(lru_t t, way_t w);
        lru_t n;
        n = t;
        n[0] = ~w[1];
        if (w[1])
            n[2] = ~w[0];
        else
            n[1] = ~w[0];
        return n;
    endfunction

    assign cur_tree = tree_q[lru.index];
    assign tree_way = cur_tree[0] ? {1'b1, cur_tree[2]} : {1'b0, cur_tree[1]};

    always_comb begin
        lru.victim = tree_way;
        for (int w = WAYS - 1; w >= 0; w--) begin
            if (!lru.fill_valid_mask[w])
                lru.victim = way_t'(w);  // lowest empty way wins
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            tree_q <= '0;
        end else if (lru.touch) begin
            tree_q[lru.index] <= point_away(cur_tree, lru.touch_way);
        end
    end

    // a hit way must be one the controller reports as valid
    a_touch_valid_way: assert property (@(posedge clk) disable iff (reset)
        lru.touch |-> lru.fill_valid_mask[lru.touch_way]);

    // a full set never names the way it just used
    a_victim_not_recent: assert property (@(posedge clk) disable iff (reset)
        lru.touch |=> lru.index != $past(lru.index) || !(&lru.fill_valid_mask)
            || lru.victim != $past(lru.touch_way));

endmodule

// File: lru_if.sv
`timescale 1ns/10ps

interface lru_if import cache_geom_pkg::*; #(
    parameter int SETS = 16
) ();

    localparam int INDEX_BITS = $clog2(SETS);

    logic [INDEX_BITS-1:0] index;            // set under lookup
    logic                  touch;            // hit in this cycle
    way_t                  touch_way;
    logic [WAYS-1:0]       fill_valid_mask;  // valid bits of the indexed set
    way_t                  victim;           // way to replace on a miss

    modport ctrl_mp (
        output index, touch, touch_way, fill_valid_mask,
        input  victim
    );

    modport lru_mp (
        input  index, touch, touch_way, fill_valid_mask,
        output victim
    );

endinterface

// File: mem_bus_pkg.sv
package mem_bus_pkg;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_WB_ADDR,    // victim line address on aw
        ST_WB_DATA,    // victim beats on w
        ST_FILL_ADDR,  // refill address on ar
        ST_FILL_DATA   // refill beats on r
    } cache_state_e;

    typedef enum logic [3:0] {
        SNOOP_NONE       = 4'h0,
        SNOOP_INVALIDATE = 4'hd
    } snoop_e;

    // access is 2**wlen bytes
    typedef enum logic [1:0] {
        SIZE_B = 2'd0,
        SIZE_H = 2'd1,
        SIZE_W = 2'd2,
        SIZE_D = 2'd3
    } access_size_e;

    // attribute fields that are not ported, both bursts are full lines
    localparam int         AXI_BURST_BEATS = 8;
    localparam logic [7:0] AXI_BURST_LEN   = 8'd7;  // beats minus one
    localparam logic [2:0] AXI_BURST_SIZE  = 3'd3;  // 8 bytes per beat
    localparam logic [1:0] AXI_BURST_INCR  = 2'd1;
    localparam logic [1:0] AXI_BURST_WRAP  = 2'd2;
    localparam logic [1:0] AXI_WB_BURST    = AXI_BURST_INCR;  // from the line base
    localparam logic [1:0] AXI_FILL_BURST  = AXI_BURST_WRAP;  // critical word first

endpackage

// File: cache_geom_pkg.sv
package cache_geom_pkg;

    localparam int ADDR_BITS   = 32;
    localparam int DATA_BITS   = 64;
    localparam int WORD_BYTES  = 8;  // bytes per data word
    localparam int LINE_WORDS  = 8;  // words per line
    localparam int BYTE_BITS   = 3;  // byte within a word
    localparam int OFFSET_BITS = 3;  // word within a line
    localparam int LINE_BITS   = OFFSET_BITS + BYTE_BITS;

    // fixed, the tree encoding below assumes four ways
    localparam int WAYS = 4;

    typedef logic [ADDR_BITS-1:0]   addr_t;
    typedef logic [DATA_BITS-1:0]   data_t;
    typedef logic [OFFSET_BITS-1:0] offset_t;
    typedef logic [BYTE_BITS-1:0]   byte_off_t;
    typedef logic [1:0]             way_t;

    // tree bits of one set
    // bit 0 picks the half, bit 1 picks in ways 0/1, bit 2 picks in ways 2/3
    typedef logic [2:0] lru_t;

    // index and tag widths follow the set count, so the modules derive them
    // as ADDR_BITS - $clog2(SETS) - LINE_BITS for the tag

endpackage
